// File: design/mem_cfg_pkg.sv
// memory geometry defaults: data width, banks, rows, write buffer depth, address split.
package mem_cfg_pkg;

  // data word width.
  localparam int DATA_W = 16;

  localparam int NUM_BANKS = 4;

  // rows per bank, also the cache entry count.
  localparam int NUM_ROWS = 64;

  // write buffer entries and starting credits.
  localparam int WBUF_DEPTH = 4;

  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int ROW_W = $clog2(NUM_ROWS);

  // bank number in the low bits, row above it.
  localparam int ADDR_W = BANK_W + ROW_W;

endpackage

// File: design/mem_ops_pkg.sv
// controller state enum and per-bank operation enum.
package mem_ops_pkg;

  // init clears the cache valid bits, run is normal traffic.
  typedef enum logic {
    st_init,
    st_run
  } ctrl_state_e;

  // what a bank does in one cycle.
  typedef enum logic [1:0] {
    op_idle  = 2'd0,
    op_read  = 2'd1,
    op_write = 2'd2
  } bank_op_e;

endpackage

// File: design/bank_if.sv
// interface for one single-port bank: op, row address, write data and read data.
`timescale 1ns/1ns

interface bank_if #(
  parameter int ADDR_W = mem_cfg_pkg::ROW_W,
  parameter int DATA_W = mem_cfg_pkg::DATA_W
);
  import mem_ops_pkg::*;

  bank_op_e          op;
  logic [ADDR_W-1:0] row;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;

  modport ctrl (
    output op,
    output row,
    output wdata,
    input  rdata
  );

  modport bank (
    input  op,
    input  row,
    input  wdata,
    output rdata
  );

endinterface

// File: design/write_credit_buffer.sv
// write FIFO in front of the bank controller, with credit return per retired write.
`timescale 1ns/1ns

module write_credit_buffer #(
  parameter int DEPTH  = mem_cfg_pkg::WBUF_DEPTH,
  parameter int ADDR_W = mem_cfg_pkg::ADDR_W,
  parameter int DATA_W = mem_cfg_pkg::DATA_W
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              write,
  input  logic [ADDR_W-1:0] wr_adr_in,
  input  logic [DATA_W-1:0] din,
  input  logic              wr_take,
  output logic              wr_valid,
  output logic [ADDR_W-1:0] wr_adr,
  output logic [DATA_W-1:0] wr_data,
  output logic              wr_credit
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [ADDR_W-1:0] adr_mem [DEPTH];
  logic [DATA_W-1:0] data_mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (write) begin
      adr_mem[wr_ptr]  <= wr_adr_in;
      data_mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (write) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (wr_take) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({write, wr_take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head entry, offered to the controller.
  assign wr_valid  = (count != '0);
  assign wr_adr    = adr_mem[rd_ptr];
  assign wr_data   = data_mem[rd_ptr];
  assign wr_credit = wr_take && wr_valid;

  // a writer that keeps to its credits never finds the buffer full without a take.
  assert property (@(posedge clk) disable iff (rst)
    write |-> (count < CNT_W'(DEPTH)) || wr_take)
    else $error("write_credit_buffer: write arrived while full");

endmodule

// File: design/bank_ctrl.sv
// bank controller: steers reads, writes and evictions to banks or cache, clears cache at start.
`timescale 1ns/1ns

module bank_ctrl #(
  parameter int  NUM_BANKS = mem_cfg_pkg::NUM_BANKS,
  parameter int  NUM_ROWS  = mem_cfg_pkg::NUM_ROWS,
  parameter int  ADDR_W    = mem_cfg_pkg::ADDR_W,
  parameter int  DATA_W    = mem_cfg_pkg::DATA_W,
  localparam int BANK_W    = $clog2(NUM_BANKS),
  localparam int ROW_W     = $clog2(NUM_ROWS)
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              read,
  input  logic [ADDR_W-1:0] rd_adr,
  input  logic              wr_valid,
  input  logic [ADDR_W-1:0] wr_adr,
  input  logic [DATA_W-1:0] wr_data,
  input  logic              hit_valid,
  input  logic [BANK_W-1:0] hit_bank,
  input  logic [DATA_W-1:0] hit_data,
  input  logic              wr_ent_valid,
  input  logic [BANK_W-1:0] wr_ent_bank,
  input  logic [DATA_W-1:0] wr_ent_data,
  output logic              ready,
  output logic              wr_take,
  output logic              rd_cache_hit,
  output logic [BANK_W-1:0] rd_bank,
  output logic [DATA_W-1:0] rd_cache_data,
  output logic [ROW_W-1:0]  rd_look_row,
  output logic [ROW_W-1:0]  wr_look_row,
  output logic              cache_we,
  output logic [ROW_W-1:0]  cache_row,
  output logic              cache_valid,
  output logic [BANK_W-1:0] cache_bank,
  output logic [DATA_W-1:0] cache_data,
  bank_if.ctrl              banks [NUM_BANKS]
);
  import mem_ops_pkg::*;

  ctrl_state_e          state;
  logic [ROW_W-1:0]     init_row;
  logic [ROW_W-1:0]     rd_row;
  logic [BANK_W-1:0]    wr_bank;
  logic [ROW_W-1:0]     wr_row;
  logic                 rd_go;
  logic                 wr_go;
  logic                 conflict;
  logic [NUM_BANKS-1:0] rd_sel;
  logic [NUM_BANKS-1:0] wr_sel;
  logic [NUM_BANKS-1:0] ev_sel;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_init;
      init_row <= '0;
    end else if (state == st_init) begin
      init_row <= init_row + 1'b1;
      if (init_row == ROW_W'(NUM_ROWS - 1)) begin
        state <= st_run;
      end
    end
  end

  assign rd_bank  = rd_adr[BANK_W-1:0];
  assign rd_row   = rd_adr[ADDR_W-1:BANK_W];
  assign wr_bank  = wr_adr[BANK_W-1:0];
  assign wr_row   = wr_adr[ADDR_W-1:BANK_W];
  assign ready    = (state == st_run);
  assign rd_go    = read && ready;
  assign wr_go    = wr_valid && ready;
  assign wr_take  = wr_go;
  // the read keeps the bank.
  assign conflict = rd_go && wr_go && (wr_bank == rd_bank);

  assign rd_look_row   = rd_row;
  assign wr_look_row   = wr_row;
  assign rd_cache_hit  = rd_go && hit_valid && (hit_bank == rd_bank);
  assign rd_cache_data = hit_data;

  always_comb begin
    rd_sel      = '0;
    wr_sel      = '0;
    ev_sel      = '0;
    cache_we    = 1'b0;
    cache_row   = wr_row;
    cache_valid = 1'b0;
    cache_bank  = wr_bank;
    cache_data  = wr_data;
    if (state == st_init) begin
      cache_we  = 1'b1;
      cache_row = init_row;
    end else begin
      if (rd_go) begin
        rd_sel[rd_bank] = 1'b1;
      end
      if (conflict) begin
        cache_we    = 1'b1;
        cache_valid = 1'b1;
        // displaced entry goes home. its bank differs from the read's.
        if (wr_ent_valid && (wr_ent_bank != wr_bank)) begin
          ev_sel[wr_ent_bank] = 1'b1;
        end
      end else if (wr_go) begin
        wr_sel[wr_bank] = 1'b1;
        // stale cached copy of this address.
        if (wr_ent_valid && (wr_ent_bank == wr_bank)) begin
          cache_we = 1'b1;
        end
      end
    end
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    assign banks[b].op    = rd_sel[b] ? op_read :
                            ((wr_sel[b] || ev_sel[b]) ? op_write : op_idle);
    assign banks[b].row   = rd_sel[b] ? rd_row : wr_row;
    assign banks[b].wdata = ev_sel[b] ? wr_ent_data : wr_data;
  end

  // read, write and eviction never land on the same bank.
  assert property (@(posedge clk) disable iff (rst)
    ((rd_sel & wr_sel) | (rd_sel & ev_sel) | (wr_sel & ev_sel)) == '0)
    else $error("bank_ctrl: two ops on one bank");

endmodule

// File: design/conflict_cache.sv
// conflict cache: per-row valid bit, bank tag and data, two lookups and one update.
`timescale 1ns/1ns

module conflict_cache #(
  parameter int  NUM_ROWS = mem_cfg_pkg::NUM_ROWS,
  parameter int  BANK_W   = mem_cfg_pkg::BANK_W,
  parameter int  DATA_W   = mem_cfg_pkg::DATA_W,
  localparam int ROW_W    = $clog2(NUM_ROWS)
) (
  input  logic              clk,
  input  logic [ROW_W-1:0]  rd_look_row,
  input  logic [ROW_W-1:0]  wr_look_row,
  input  logic              cache_we,
  input  logic [ROW_W-1:0]  cache_row,
  input  logic              cache_valid,
  input  logic [BANK_W-1:0] cache_bank,
  input  logic [DATA_W-1:0] cache_data,
  output logic              hit_valid,
  output logic [BANK_W-1:0] hit_bank,
  output logic [DATA_W-1:0] hit_data,
  output logic              wr_ent_valid,
  output logic [BANK_W-1:0] wr_ent_bank,
  output logic [DATA_W-1:0] wr_ent_data
);
  logic              valid_tbl [NUM_ROWS];
  logic [BANK_W-1:0] tag_tbl [NUM_ROWS];
  logic [DATA_W-1:0] data_tbl [NUM_ROWS];

  always_ff @(posedge clk) begin
    if (cache_we) begin
      valid_tbl[cache_row] <= cache_valid;
      tag_tbl[cache_row]   <= cache_bank;
      data_tbl[cache_row]  <= cache_data;
    end
  end

  // entry at the read row.
  assign hit_valid = valid_tbl[rd_look_row];
  assign hit_bank  = tag_tbl[rd_look_row];
  assign hit_data  = data_tbl[rd_look_row];

  // entry at the write row, for eviction and invalidation.
  assign wr_ent_valid = valid_tbl[wr_look_row];
  assign wr_ent_bank  = tag_tbl[wr_look_row];
  assign wr_ent_data  = data_tbl[wr_look_row];

endmodule

// File: design/sram_1rw.sv
// single-port bank model with one-cycle registered read.
`timescale 1ns/1ns

module sram_1rw #(
  parameter int NUM_ROWS = mem_cfg_pkg::NUM_ROWS,
  parameter int DATA_W   = mem_cfg_pkg::DATA_W
) (
  input logic  clk,
  bank_if.bank bus
);
  import mem_ops_pkg::*;

  logic [DATA_W-1:0] mem [NUM_ROWS];

  always_ff @(posedge clk) begin
    case (bus.op)
      op_write: mem[bus.row] <= bus.wdata;
      op_read:  bus.rdata <= mem[bus.row];
      default:  ;
    endcase
  end

  // controller only issues the three legal ops.
  assert property (@(posedge clk) bus.op inside {op_idle, op_read, op_write})
    else $error("sram_1rw: illegal bank op");

endmodule

// File: design/read_return.sv
// read response: aligns cache-hit data with bank data and registers the result.
`timescale 1ns/1ns

module read_return #(
  parameter int  NUM_BANKS = mem_cfg_pkg::NUM_BANKS,
  parameter int  DATA_W    = mem_cfg_pkg::DATA_W,
  localparam int BANK_W    = $clog2(NUM_BANKS)
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             read,
  input  logic                             rd_cache_hit,
  input  logic [BANK_W-1:0]                rd_bank,
  input  logic [DATA_W-1:0]                rd_cache_data,
  input  logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rdata,
  output logic                             rd_vld,
  output logic [DATA_W-1:0]                rd_dout
);
  logic              rd_q;
  logic              hit_q;
  logic [BANK_W-1:0] bank_q;
  logic [DATA_W-1:0] cdata_q;

  // stage one lines up with the bank read data.
  always_ff @(posedge clk) begin
    hit_q   <= rd_cache_hit;
    bank_q  <= rd_bank;
    cdata_q <= rd_cache_data;
    rd_dout <= hit_q ? cdata_q : bank_rdata[bank_q];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q   <= 1'b0;
      rd_vld <= 1'b0;
    end else begin
      rd_q   <= read;
      rd_vld <= rd_q;
    end
  end

endmodule

// File: design/mem_1r1w_top.sv
// 1r1w memory top: write buffer, bank controller, conflict cache, banks and read return.
`timescale 1ns/1ns

module mem_1r1w_top #(
  parameter int DATA_W     = mem_cfg_pkg::DATA_W,
  parameter int NUM_BANKS  = mem_cfg_pkg::NUM_BANKS,
  parameter int NUM_ROWS   = mem_cfg_pkg::NUM_ROWS,
  parameter int WBUF_DEPTH = mem_cfg_pkg::WBUF_DEPTH,
  parameter int ADDR_W     = mem_cfg_pkg::ADDR_W
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              write,
  input  logic [ADDR_W-1:0] wr_adr,
  input  logic [DATA_W-1:0] din,
  input  logic              read,
  input  logic [ADDR_W-1:0] rd_adr,
  output logic              ready,
  output logic              wr_credit,
  output logic              rd_vld,
  output logic [DATA_W-1:0] rd_dout
);
  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int ROW_W  = $clog2(NUM_ROWS);

  logic                             wr_valid;
  logic [ADDR_W-1:0]                head_adr;
  logic [DATA_W-1:0]                head_data;
  logic                             wr_take;
  logic                             hit_valid;
  logic [BANK_W-1:0]                hit_bank;
  logic [DATA_W-1:0]                hit_data;
  logic                             wr_ent_valid;
  logic [BANK_W-1:0]                wr_ent_bank;
  logic [DATA_W-1:0]                wr_ent_data;
  logic [ROW_W-1:0]                 rd_look_row;
  logic [ROW_W-1:0]                 wr_look_row;
  logic                             cache_we;
  logic [ROW_W-1:0]                 cache_row;
  logic                             cache_valid;
  logic [BANK_W-1:0]                cache_bank;
  logic [DATA_W-1:0]                cache_data;
  logic                             rd_cache_hit;
  logic [BANK_W-1:0]                rd_bank;
  logic [DATA_W-1:0]                rd_cache_data;
  logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rdata;
  logic                             rd_go;

  bank_if #(.ADDR_W(ROW_W), .DATA_W(DATA_W)) bank_bus [NUM_BANKS] ();

  // reads before ready are dropped.
  assign rd_go = read && ready;

  write_credit_buffer #(.DEPTH(WBUF_DEPTH), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_wbuf (
    .clk       (clk),
    .rst       (rst),
    .write     (write),
    .wr_adr_in (wr_adr),
    .din       (din),
    .wr_take   (wr_take),
    .wr_valid  (wr_valid),
    .wr_adr    (head_adr),
    .wr_data   (head_data),
    .wr_credit (wr_credit)
  );

  bank_ctrl #(
    .NUM_BANKS (NUM_BANKS),
    .NUM_ROWS  (NUM_ROWS),
    .ADDR_W    (ADDR_W),
    .DATA_W    (DATA_W)
  ) u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .read          (read),
    .rd_adr        (rd_adr),
    .wr_valid      (wr_valid),
    .wr_adr        (head_adr),
    .wr_data       (head_data),
    .hit_valid     (hit_valid),
    .hit_bank      (hit_bank),
    .hit_data      (hit_data),
    .wr_ent_valid  (wr_ent_valid),
    .wr_ent_bank   (wr_ent_bank),
    .wr_ent_data   (wr_ent_data),
    .ready         (ready),
    .wr_take       (wr_take),
    .rd_cache_hit  (rd_cache_hit),
    .rd_bank       (rd_bank),
    .rd_cache_data (rd_cache_data),
    .rd_look_row   (rd_look_row),
    .wr_look_row   (wr_look_row),
    .cache_we      (cache_we),
    .cache_row     (cache_row),
    .cache_valid   (cache_valid),
    .cache_bank    (cache_bank),
    .cache_data    (cache_data),
    .banks         (bank_bus)
  );

  conflict_cache #(.NUM_ROWS(NUM_ROWS), .BANK_W(BANK_W), .DATA_W(DATA_W)) u_cache (
    .clk          (clk),
    .rd_look_row  (rd_look_row),
    .wr_look_row  (wr_look_row),
    .cache_we     (cache_we),
    .cache_row    (cache_row),
    .cache_valid  (cache_valid),
    .cache_bank   (cache_bank),
    .cache_data   (cache_data),
    .hit_valid    (hit_valid),
    .hit_bank     (hit_bank),
    .hit_data     (hit_data),
    .wr_ent_valid (wr_ent_valid),
    .wr_ent_bank  (wr_ent_bank),
    .wr_ent_data  (wr_ent_data)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    sram_1rw #(.NUM_ROWS(NUM_ROWS), .DATA_W(DATA_W)) u_sram (
      .clk (clk),
      .bus (bank_bus[b])
    );
    assign bank_rdata[b] = bank_bus[b].rdata;
  end

  read_return #(.NUM_BANKS(NUM_BANKS), .DATA_W(DATA_W)) u_ret (
    .clk           (clk),
    .rst           (rst),
    .read          (rd_go),
    .rd_cache_hit  (rd_cache_hit),
    .rd_bank       (rd_bank),
    .rd_cache_data (rd_cache_data),
    .bank_rdata    (bank_rdata),
    .rd_vld        (rd_vld),
    .rd_dout       (rd_dout)
  );

endmodule

// File: sim/tb_tasks.svh
// directed tests for the 1r1w memory and the value compare task.
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("ERR %s expected %0h actual %0h", name, exp, act);
  end
endtask

// writes during the clearing phase wait in the buffer.
task automatic test_early_writes();
  int got;
  test_name = "early_writes";
  got = 0;
  for (int i = 0; i < WBUF_DEPTH; i++) begin
    next_cycle();
    issue_write(ADDR_W'(i), fill_word(ADDR_W'(i), 4'd1));
  end
  next_cycle();
  while (!ready) begin
    compare_value(test_name, 32'd0, 32'(wr_credit));
    next_cycle();
  end
  for (int i = 0; i < WBUF_DEPTH + 2; i++) begin
    got = got + int'(wr_credit);
    next_cycle();
  end
  compare_value(test_name, 32'(WBUF_DEPTH), 32'(got));
  compare_value({test_name, " credits"}, 32'(WBUF_DEPTH), 32'(credits));
endtask

task automatic test_ready_delay();
  test_name = "ready_delay";
  compare_value(test_name, 32'(NUM_ROWS), 32'(low_cycles));
endtask

task automatic test_bank_fill();
  logic [ADDR_W-1:0] a;
  test_name = "bank_fill";
  for (int i = 0; i < FILL_N; i++) begin
    a = ADDR_W'(FILL_BASE + i);
    next_cycle();
    issue_write(a, fill_word(a, 4'd2));
  end
  wait_idle();
  read_range(FILL_BASE, FILL_N);
endtask

// each write retires against a read of its own bank, other row.
task automatic test_same_bank();
  logic [ADDR_W-1:0] wa;
  test_name = "same_bank";
  for (int b = 0; b < NUM_BANKS; b++) begin
    wa = row_adr(FILL_ROW + b % FILL_ROWS, b);
    next_cycle();
    issue_write(wa, fill_word(wa, 4'd3));
    next_cycle();
    issue_read(row_adr(FILL_ROW + (b + 1) % FILL_ROWS, b));
    next_cycle();
    issue_read(wa);
  end
  wait_idle();
  read_range(FILL_BASE, FILL_N);
endtask

// one row, every bank, two rounds, so each cache fill displaces another bank.
task automatic test_evict();
  logic [ADDR_W-1:0] wa;
  test_name = "evict";
  for (int r = 0; r < 2; r++) begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      wa = row_adr(EVICT_ROW, b);
      next_cycle();
      issue_write(wa, fill_word(wa, 4'(4 + r)));
      next_cycle();
      issue_read(row_adr(FILL_ROW, b));
    end
  end
  wait_idle();
  read_range(EVICT_ROW * NUM_BANKS, NUM_BANKS);
  read_range(FILL_BASE, NUM_BANKS);
endtask

task automatic test_random();
  int r;
  test_name = "random";
  for (int i = 0; i < RAND_CYCLES; i++) begin
    next_cycle();
    r = $random(seed);
    if (r[0] && credits > 0) begin
      issue_write(ADDR_W'(FILL_BASE + r[5:2]), DATA_W'(r[31:16]));
    end
    if (r[1]) begin
      issue_read(ADDR_W'(FILL_BASE + r[9:6]));
    end
  end
  wait_idle();
  read_range(FILL_BASE, FILL_N);
endtask

`endif

// File: sim/tb_mem_1r1w.sv
// testbench top: clock, reset, DUT, reference model, cycle stepping, timeout and report.
`timescale 1ns/1ns

module tb_mem_1r1w;
  import mem_cfg_pkg::*;

  localparam int FILL_ROW    = 4;
  localparam int FILL_ROWS   = 4;
  localparam int FILL_BASE   = FILL_ROW * NUM_BANKS;
  localparam int FILL_N      = FILL_ROWS * NUM_BANKS;
  localparam int EVICT_ROW   = 2;
  localparam int RAND_CYCLES = 300;
  // about twice the summed test lengths and drains.
  localparam int MAX_CYCLES  = 2 * (4 + NUM_ROWS + 8 + 6 * FILL_N + RAND_CYCLES);

  logic              clk;
  logic              rst;
  logic              write;
  logic [ADDR_W-1:0] wr_adr;
  logic [DATA_W-1:0] din;
  logic              read;
  logic [ADDR_W-1:0] rd_adr;
  logic              ready;
  logic              wr_credit;
  logic              rd_vld;
  logic [DATA_W-1:0] rd_dout;

  // reference model, updated only by retired writes.
  logic [DATA_W-1:0] ref_mem [2**ADDR_W];
  logic              known [2**ADDR_W];

  // writes in the buffer, oldest first.
  logic [ADDR_W-1:0] wr_pend_adr [$];
  logic [DATA_W-1:0] wr_pend_data [$];

  // reads in flight and the cycle their data is due.
  int                rd_due [$];
  logic [DATA_W-1:0] rd_exp [$];
  logic              rd_chk [$];

  int    cycle;
  int    credits;
  int    low_cycles;
  int    checks;
  int    errors;
  int    seed;
  logic  retire_due;
  string test_name;

  mem_1r1w_top #(
    .DATA_W     (DATA_W),
    .NUM_BANKS  (NUM_BANKS),
    .NUM_ROWS   (NUM_ROWS),
    .WBUF_DEPTH (WBUF_DEPTH),
    .ADDR_W     (ADDR_W)
  ) dut_i (
    .clk       (clk),
    .rst       (rst),
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .read      (read),
    .rd_adr    (rd_adr),
    .ready     (ready),
    .wr_credit (wr_credit),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [ADDR_W-1:0] row_adr(input int row, input int bank);
    return ADDR_W'(row * NUM_BANKS + bank);
  endfunction

  // odd multiplier spreads every address bit into the word.
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] adr,
                                                  input logic [3:0] round);
    return DATA_W'((32'(adr) * 32'h9e37) ^ (32'(round) << 12));
  endfunction

  task automatic reset_dut();
    rst = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    compare_value("reset_outputs", 32'd0, 32'({ready, wr_credit, rd_vld}));
    // release cycle is the first clearing cycle.
    low_cycles = ready ? 0 : 1;
    credits = WBUF_DEPTH;
  endtask

  task automatic retire_write();
    if (wr_pend_adr.size() == 0) begin
      errors++;
      $display("wr_credit pulsed in %s with no write waiting to retire", test_name);
    end else begin
      ref_mem[wr_pend_adr[0]] = wr_pend_data[0];
      known[wr_pend_adr[0]] = 1'b1;
      void'(wr_pend_adr.pop_front());
      void'(wr_pend_data.pop_front());
    end
    retire_due = 1'b0;
  endtask

  // moves to the next falling edge, checks the read port, counts credits.
  task automatic next_cycle();
    if (retire_due) begin
      retire_write();
    end
    @(negedge clk);
    cycle++;
    write = 1'b0;
    read  = 1'b0;
    if (!ready) begin
      low_cycles++;
    end
    if (rd_due.size() > 0 && rd_due[0] == cycle) begin
      compare_value({test_name, " rd_vld"}, 32'd1, 32'(rd_vld));
      if (rd_chk[0]) begin
        compare_value(test_name, 32'(rd_exp[0]), 32'(rd_dout));
      end
      void'(rd_due.pop_front());
      void'(rd_exp.pop_front());
      void'(rd_chk.pop_front());
    end else begin
      compare_value({test_name, " rd_vld"}, 32'd0, 32'(rd_vld));
    end
    // the head retires at the coming rising edge.
    retire_due = wr_credit;
    if (wr_credit) begin
      credits++;
    end
  endtask

  // a wait for credit steps the cycle and clears the inputs.
  task automatic issue_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] data);
    while (credits == 0) begin
      next_cycle();
    end
    write  = 1'b1;
    wr_adr = adr;
    din    = data;
    credits--;
    wr_pend_adr.push_back(adr);
    wr_pend_data.push_back(data);
  endtask

  task automatic issue_read(input logic [ADDR_W-1:0] adr);
    read   = 1'b1;
    rd_adr = adr;
    // reads before ready are dropped by the DUT.
    if (ready) begin
      rd_due.push_back(cycle + 2);
      rd_exp.push_back(ref_mem[adr]);
      rd_chk.push_back(known[adr]);
    end
  endtask

  task automatic wait_idle();
    while (wr_pend_adr.size() > 0 || rd_due.size() > 0) begin
      next_cycle();
    end
  endtask

  task automatic read_range(input int base, input int n);
    for (int i = 0; i < n; i++) begin
      next_cycle();
      issue_read(ADDR_W'(base + i));
    end
    wait_idle();
  endtask

  `include "tb_tasks.svh"

  initial begin
    int wd;
    wd = 0;
    while (wd < MAX_CYCLES) begin
      @(posedge clk);
      wd++;
    end
    $display("timeout after %0d cycles, the tests did not finish", wd);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    write      = 1'b0;
    wr_adr     = '0;
    din        = '0;
    read       = 1'b0;
    rd_adr     = '0;
    cycle      = 0;
    checks     = 0;
    errors     = 0;
    retire_due = 1'b0;
    seed       = 97724;
    test_name  = "reset";
    for (int a = 0; a < 2**ADDR_W; a++) begin
      known[a] = 1'b0;
    end
    reset_dut();
    test_early_writes();
    test_ready_delay();
    test_bank_fill();
    test_same_bank();
    test_evict();
    test_random();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: mem_1r1w.f
+incdir+sim
design/mem_cfg_pkg.sv
design/mem_ops_pkg.sv
design/bank_if.sv
design/write_credit_buffer.sv
design/bank_ctrl.sv
design/conflict_cache.sv
design/sram_1rw.sv
design/read_return.sv
design/mem_1r1w_top.sv
sim/tb_mem_1r1w.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_mem_1r1w
FILELIST   := mem_1r1w.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only when the pass message shows up in its output.
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
